/* source/rammodel_pkg.sv */
package rammodel_pkg;

    // burst length field, beats minus one
    localparam int LEN_BITS = 8;

    typedef logic [LEN_BITS-1:0] len_t;

    // width of the delay inputs and the cycle counter
    localparam int DEFAULT_DELAY_BITS = 16;

    // write tracker states
    typedef enum logic {
        ADDR_WAIT,
        DATA_WAIT
    } wr_state_e;

endpackage

/* source/sched_if.sv */
`timescale 1ns/1ps

// one pending response request, valid/ready handshake
interface sched_if #(
    parameter int ID_WIDTH = 4
);
    import rammodel_pkg::*;

    logic                valid;
    logic                ready;
    logic [ID_WIDTH-1:0] id;
    len_t                len;

    modport source (
        output valid,
        output id,
        output len,
        input  ready
    );

    modport sink (
        input  valid,
        input  id,
        input  len,
        output ready
    );

endinterface

/* source/rv_fifo.sv */
`timescale 1ns/1ps

module rv_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             ivalid,
    output logic             iready,
    input  logic [WIDTH-1:0] idata,
    output logic             ovalid,
    input  logic             oready,
    output logic [WIDTH-1:0] odata
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             push;
    logic             pop;

    assign iready = (count != CW'(DEPTH));
    assign ovalid = (count != '0);
    // head shown without a read cycle
    assign odata  = mem[rd_ptr];

    assign push = ivalid && iready;
    assign pop  = ovalid && oready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= idata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a push while full would overwrite the head entry
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        (count == CW'(DEPTH)) && !pop |=> (count == CW'(DEPTH)) && $stable(odata));

    // a pop while empty would wrap the count
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        (count == '0) |=> (count <= CW'(1)));

endmodule

/* source/delay_scheduler.sv */
`timescale 1ns/1ps

module delay_scheduler #(
    parameter int ID_WIDTH   = 4,
    parameter int DELAY_BITS = rammodel_pkg::DEFAULT_DELAY_BITS,
    parameter int DEPTH      = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [DELAY_BITS-1:0] delay,
    sched_if.sink                 in,
    sched_if.source               out
);
    import rammodel_pkg::*;

    localparam int WAIT_W = DELAY_BITS + ID_WIDTH + LEN_BITS;
    localparam int DONE_W = ID_WIDTH + LEN_BITS;

    logic [DELAY_BITS-1:0] cycle;
    logic [DELAY_BITS-1:0] stamp;
    logic [DELAY_BITS-1:0] elapsed;

    logic                  wait_ovalid;
    logic                  wait_oready;
    logic [DELAY_BITS-1:0] head_stamp;
    logic [ID_WIDTH-1:0]   head_id;
    len_t                  head_len;
    logic                  head_due;

    logic                  done_ivalid;
    logic                  done_iready;
    logic [DONE_W-1:0]     done_odata;

    // free-running, wraps
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    assign stamp = cycle + delay;

    rv_fifo #(
        .WIDTH  (WAIT_W),
        .DEPTH  (DEPTH)
    ) wait_q (
        .clk    (clk),
        .rst    (rst),
        .ivalid (in.valid),
        .iready (in.ready),
        .idata  ({stamp, in.id, in.len}),
        .ovalid (wait_ovalid),
        .oready (wait_oready),
        .odata  ({head_stamp, head_id, head_len})
    );

    // due once the counter has reached or passed the stamp
    assign elapsed  = cycle - head_stamp;
    assign head_due = !elapsed[DELAY_BITS-1];

    assign done_ivalid = wait_ovalid && head_due;
    assign wait_oready = done_iready && head_due;

    rv_fifo #(
        .WIDTH  (DONE_W),
        .DEPTH  (DEPTH)
    ) done_q (
        .clk    (clk),
        .rst    (rst),
        .ivalid (done_ivalid),
        .iready (done_iready),
        .idata  ({head_id, head_len}),
        .ovalid (out.valid),
        .oready (out.ready),
        .odata  (done_odata)
    );

    assign out.id  = done_odata[DONE_W-1:LEN_BITS];
    assign out.len = done_odata[LEN_BITS-1:0];

    // a released response is held until taken
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out.valid && !out.ready |=> out.valid && $stable({out.id, out.len}));

endmodule

/* source/read_burst_responder.sv */
`timescale 1ns/1ps

module read_burst_responder #(
    parameter int ID_WIDTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    sched_if.sink               due,
    output logic                rvalid,
    input  logic                rready,
    output logic [ID_WIDTH-1:0] rid,
    output logic                rlast
);
    import rammodel_pkg::*;

    // beats sent so far in the current burst
    len_t beat;

    assign rvalid = due.valid;
    assign rid    = due.id;
    assign rlast  = due.valid && (beat == due.len);

    // item leaves on its final beat
    assign due.ready = rready && rlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat <= '0;
        end else if (rvalid && rready) begin
            if (rlast) begin
                beat <= '0;
            end else begin
                beat <= beat + 1'b1;
            end
        end
    end

    a_beat_in_range: assert property (@(posedge clk) disable iff (rst)
        due.valid |-> (beat <= due.len));

endmodule

/* source/write_request_tracker.sv */
`timescale 1ns/1ps

module write_request_tracker #(
    parameter int ID_WIDTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                awvalid,
    output logic                awready,
    input  logic [ID_WIDTH-1:0] awid,
    input  logic                wvalid,
    output logic                wready,
    input  logic                wlast,
    sched_if.source             req
);
    import rammodel_pkg::*;

    wr_state_e           state;
    logic [ID_WIDTH-1:0] id_q;
    logic                aw_fire;
    logic                last_fire;

    assign awready = (state == ADDR_WAIT);
    // stall data while the scheduler cannot take the response
    assign wready  = (state == DATA_WAIT) && req.ready;

    assign aw_fire   = awvalid && awready;
    assign last_fire = wvalid && wready && wlast;

    assign req.valid = (state == DATA_WAIT) && wvalid && wlast;
    assign req.id    = id_q;
    assign req.len   = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ADDR_WAIT;
        end else if (aw_fire) begin
            state <= DATA_WAIT;
        end else if (last_fire) begin
            state <= ADDR_WAIT;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            id_q <= awid;
        end
    end

    a_no_data_after_last: assert property (@(posedge clk) disable iff (rst)
        last_fire |=> (state == ADDR_WAIT) && !wready);

endmodule

/* source/timing_model_fixed.sv */
`timescale 1ns/1ps

module timing_model_fixed #(
    parameter int ID_WIDTH       = 4,
    parameter int DELAY_BITS     = rammodel_pkg::DEFAULT_DELAY_BITS,
    parameter int MAX_R_INFLIGHT = 8,
    parameter int MAX_W_INFLIGHT = 8
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  arvalid,
    output logic                  arready,
    input  logic [ID_WIDTH-1:0]   arid,
    input  rammodel_pkg::len_t    arlen,

    input  logic                  awvalid,
    output logic                  awready,
    input  logic [ID_WIDTH-1:0]   awid,

    input  logic                  wvalid,
    output logic                  wready,
    input  logic                  wlast,

    output logic                  bvalid,
    input  logic                  bready,
    output logic [ID_WIDTH-1:0]   bid,

    output logic                  rvalid,
    input  logic                  rready,
    output logic [ID_WIDTH-1:0]   rid,
    output logic                  rlast,

    input  logic [DELAY_BITS-1:0] r_delay,
    input  logic [DELAY_BITS-1:0] w_delay
);

    sched_if #(.ID_WIDTH(ID_WIDTH)) r_req ();
    sched_if #(.ID_WIDTH(ID_WIDTH)) r_due ();
    sched_if #(.ID_WIDTH(ID_WIDTH)) w_req ();
    sched_if #(.ID_WIDTH(ID_WIDTH)) w_due ();

    // read address channel straight into the scheduler
    assign r_req.valid = arvalid;
    assign r_req.id    = arid;
    assign r_req.len   = arlen;
    assign arready     = r_req.ready;

    delay_scheduler #(
        .ID_WIDTH   (ID_WIDTH),
        .DELAY_BITS (DELAY_BITS),
        .DEPTH      (MAX_R_INFLIGHT)
    ) r_sched_i (
        .clk        (clk),
        .rst        (rst),
        .delay      (r_delay),
        .in         (r_req),
        .out        (r_due)
    );

    read_burst_responder #(
        .ID_WIDTH   (ID_WIDTH)
    ) r_resp_i (
        .clk        (clk),
        .rst        (rst),
        .due        (r_due),
        .rvalid     (rvalid),
        .rready     (rready),
        .rid        (rid),
        .rlast      (rlast)
    );

    write_request_tracker #(
        .ID_WIDTH   (ID_WIDTH)
    ) w_track_i (
        .clk        (clk),
        .rst        (rst),
        .awvalid    (awvalid),
        .awready    (awready),
        .awid       (awid),
        .wvalid     (wvalid),
        .wready     (wready),
        .wlast      (wlast),
        .req        (w_req)
    );

    delay_scheduler #(
        .ID_WIDTH   (ID_WIDTH),
        .DELAY_BITS (DELAY_BITS),
        .DEPTH      (MAX_W_INFLIGHT)
    ) w_sched_i (
        .clk        (clk),
        .rst        (rst),
        .delay      (w_delay),
        .in         (w_req),
        .out        (w_due)
    );

    // write responses carry no length
    assign bvalid      = w_due.valid;
    assign bid         = w_due.id;
    assign w_due.ready = bready;

endmodule

/* test/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// expected read bursts, oldest first
logic [ID_W-1:0] exp_r_id[$];
len_t            exp_r_len[$];
int              exp_r_due[$];
bit              exp_r_exact[$];

// expected write responses, oldest first
logic [ID_W-1:0] exp_b_id[$];
int              exp_b_due[$];
bit              exp_b_exact[$];

// first response is seen delay+1 cycles after the accepting edge
function automatic int due_cycle(input int accept_cyc, input int dly);
    return accept_cyc + dly + 1;
endfunction

function automatic int beat_count(input len_t len);
    return int'(len) + 1;
endfunction

function automatic void expect_read(input logic [ID_W-1:0] id, input len_t len,
                                    input int accept_cyc, input int dly);
    // exact only with nothing queued ahead
    exp_r_exact.push_back(exp_r_id.size() == 0);
    exp_r_id.push_back(id);
    exp_r_len.push_back(len);
    exp_r_due.push_back(due_cycle(accept_cyc, dly));
endfunction

function automatic void expect_write(input logic [ID_W-1:0] id, input int accept_cyc,
                                     input int dly);
    exp_b_exact.push_back(exp_b_id.size() == 0);
    exp_b_id.push_back(id);
    exp_b_due.push_back(due_cycle(accept_cyc, dly));
endfunction

function automatic void drop_read();
    void'(exp_r_id.pop_front());
    void'(exp_r_len.pop_front());
    void'(exp_r_due.pop_front());
    void'(exp_r_exact.pop_front());
endfunction

function automatic void drop_write();
    void'(exp_b_id.pop_front());
    void'(exp_b_due.pop_front());
    void'(exp_b_exact.pop_front());
endfunction

`endif

/* test/tb_timing_model.sv */
`timescale 1ns/1ps

module tb_timing_model;
    import rammodel_pkg::*;

    localparam int ID_W        = 4;
    localparam int DELAY_BITS  = DEFAULT_DELAY_BITS;
    localparam int MAX_DELAY   = 60;
    localparam int NUM_REQ     = 68;
    localparam int CYCLE_LIMIT = NUM_REQ * (MAX_DELAY + 256) + 1000;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  arvalid, arready;
    logic [ID_W-1:0]       arid;
    len_t                  arlen;
    logic                  awvalid, awready;
    logic [ID_W-1:0]       awid;
    logic                  wvalid, wready, wlast;
    logic                  bvalid, bready;
    logic [ID_W-1:0]       bid;
    logic                  rvalid, rready, rlast;
    logic [ID_W-1:0]       rid;
    logic [DELAY_BITS-1:0] r_delay, w_delay;

    int              cyc = 0;
    int              errors = 0;
    int              checks = 0;
    int              rst_edges = 0;
    int              r_beat = 0;
    int              reads_done = 0;
    int              writes_done = 0;
    bit              post_rst = 1'b0;
    bit              rand_ready = 1'b0;
    bit              r_seen = 1'b0;
    bit              b_seen = 1'b0;
    bit              w_open = 1'b0;
    logic [ID_W-1:0] w_id;

    `include "tb_ref_model.svh"

    always #5 clk = ~clk;

    timing_model_fixed #(
        .ID_WIDTH       (ID_W),
        .DELAY_BITS     (DELAY_BITS),
        .MAX_R_INFLIGHT (8),
        .MAX_W_INFLIGHT (8)
    ) dut_i (.*);

    task automatic report_error(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    task automatic compare_read_beat(input logic [ID_W-1:0] got_id, input logic [ID_W-1:0] exp_id,
                                     input logic got_last, input len_t beat, input len_t last_beat);
        checks++;
        if (got_id !== exp_id) begin
            errors++;
            $display("[FAIL] rid got 0x%h expected 0x%h", got_id, exp_id);
        end
        if (got_last !== (beat == last_beat)) begin
            errors++;
            $display("[FAIL] rlast got 0x%h expected 0x%h", got_last, beat == last_beat);
        end
    endtask

    task automatic compare_write_resp(input logic [ID_W-1:0] got_id, input logic [ID_W-1:0] exp_id);
        checks++;
        if (got_id !== exp_id) begin
            errors++;
            $display("[FAIL] bid got 0x%h expected 0x%h", got_id, exp_id);
        end
    endtask

    task automatic check_arrival(input string name, input int got, input int due, input bit exact);
        checks++;
        if (exact ? (got != due) : (got < due)) begin
            errors++;
            $display("[FAIL] %s cycle got 0x%h expected %s0x%h", name, got,
                     exact ? "" : "at least ", due);
        end
    endtask

    task automatic check_reset_low();
        checks++;
        if ({wready, rvalid, bvalid} !== 3'b000) begin
            errors++;
            $display("[FAIL] {wready,rvalid,bvalid} got 0x%h expected 0x0",
                     {wready, rvalid, bvalid});
        end
    endtask

    task automatic watch_read_channel();
        if (r_seen && !rvalid) begin
            report_error("rvalid dropped before the read burst completed");
            r_seen = 1'b0;
        end
        if (rvalid && exp_r_id.size() == 0) begin
            report_error("read beat with no read outstanding");
        end else if (rvalid) begin
            if (!r_seen) begin
                check_arrival("rvalid", cyc, exp_r_due[0], exp_r_exact[0]);
                r_seen = 1'b1;
            end
            if (rready) begin
                compare_read_beat(rid, exp_r_id[0], rlast, len_t'(r_beat), exp_r_len[0]);
                r_beat++;
                if (r_beat == beat_count(exp_r_len[0])) begin
                    drop_read();
                    r_beat = 0;
                    r_seen = 1'b0;
                    reads_done++;
                end
            end
        end
        if (arvalid && arready) begin
            expect_read(arid, arlen, cyc, int'(r_delay));
        end
    endtask

    task automatic watch_write_channel();
        if (b_seen && !bvalid) begin
            report_error("bvalid dropped before the response was taken");
            b_seen = 1'b0;
        end
        if (bvalid && exp_b_id.size() == 0) begin
            report_error("write response with no write outstanding");
        end else if (bvalid) begin
            if (!b_seen) begin
                check_arrival("bvalid", cyc, exp_b_due[0], exp_b_exact[0]);
                b_seen = 1'b1;
            end
            if (bready) begin
                compare_write_resp(bid, exp_b_id[0]);
                drop_write();
                b_seen = 1'b0;
                writes_done++;
            end
        end
        if (w_open && awready) begin
            report_error("awready high while a write burst is open");
        end
        if (!w_open && wready) begin
            report_error("wready high with no write address accepted");
        end
        if (awvalid && awready) begin
            w_open = 1'b1;
            w_id = awid;
        end
        if (wvalid && wready && wlast) begin
            expect_write(w_id, cyc, int'(w_delay));
            w_open = 1'b0;
        end
    endtask

    // outputs sampled on the rising edge, before any register update
    always @(posedge clk) begin
        cyc++;
        if (rst) begin
            if (rst_edges > 0) begin
                check_reset_low();
            end
            rst_edges++;
            post_rst = 1'b1;
        end else begin
            if (post_rst) begin
                check_reset_low();
                post_rst = 1'b0;
            end
            watch_read_channel();
            watch_write_channel();
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            rready = rand_ready ? ($urandom_range(3) != 0) : 1'b1;
            bready = rand_ready ? ($urandom_range(2) != 0) : 1'b1;
        end
    end

    // called on a falling edge, returns on the falling edge after the handshake
    task automatic send_read(input logic [ID_W-1:0] id, input len_t len,
                             input logic [DELAY_BITS-1:0] dly);
        arvalid = 1'b1;
        arid    = id;
        arlen   = len;
        r_delay = dly;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
    endtask

    task automatic send_write(input logic [ID_W-1:0] id, input int nbeats,
                              input logic [DELAY_BITS-1:0] dly);
        awvalid = 1'b1;
        awid    = id;
        w_delay = dly;
        while (!awready) @(negedge clk);
        @(negedge clk);
        // address stays offered with another id, must not be taken
        awid = ~id;
        for (int i = 0; i < nbeats; i++) begin
            wvalid = 1'b1;
            wlast  = (i == nbeats - 1);
            while (!wready) @(negedge clk);
            @(negedge clk);
        end
        wvalid  = 1'b0;
        wlast   = 1'b0;
        awvalid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_r_id.size() != 0 || exp_b_id.size() != 0 || w_open) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic finish_run();
        $display("checks %0d errors %0d reads %0d writes %0d",
                 checks, errors, reads_done, writes_done);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    initial begin
        wait (cyc >= CYCLE_LIMIT);
        report_error($sformatf("timeout after %0d cycles", cyc));
        finish_run();
    end

    initial begin
        void'($urandom(32'h1aef_5c12));
        rst     = 1'b1;
        arvalid = 1'b0;
        arid    = '0;
        arlen   = '0;
        awvalid = 1'b0;
        awid    = '0;
        wvalid  = 1'b0;
        wlast   = 1'b0;
        bready  = 1'b0;
        rready  = 1'b0;
        r_delay = '0;
        w_delay = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        send_read(4'h3, len_t'(4), DELAY_BITS'(7));
        wait_idle();
        send_write(4'h5, 3, DELAY_BITS'(9));
        wait_idle();

        // back-to-back traffic under random ready
        rand_ready = 1'b1;
        repeat (30) begin
            send_read(ID_W'($urandom), len_t'($urandom_range(15)),
                      DELAY_BITS'($urandom_range(MAX_DELAY, 1)));
            repeat ($urandom_range(2)) @(negedge clk);
        end
        repeat (20) begin
            send_write(ID_W'($urandom), $urandom_range(4, 1),
                       DELAY_BITS'($urandom_range(MAX_DELAY, 1)));
        end
        wait_idle();

        // long delay then short, both channels at once
        rand_ready = 1'b0;
        fork
            for (int i = 0; i < 8; i++) begin
                send_read(ID_W'(i), len_t'(i), DELAY_BITS'((i % 2 == 0) ? MAX_DELAY : 2));
            end
            for (int j = 0; j < 8; j++) begin
                send_write(ID_W'(j + 8), 2, DELAY_BITS'((j % 2 == 0) ? MAX_DELAY : 2));
            end
        join
        wait_idle();

        finish_run();
    end

endmodule

/* tb.f */
+incdir+test
source/rammodel_pkg.sv
source/sched_if.sv
source/rv_fifo.sv
source/delay_scheduler.sv
source/read_burst_responder.sv
source/write_request_tracker.sv
source/timing_model_fixed.sv
test/tb_timing_model.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_timing_model -f tb.f -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation did not pass"
    exit 1
fi
